//--- compMul2to1.sv
`default_nettype none
`timescale 1ns/1ps

// Registered unsigned 8x8 multiplier.
// Product is valid one edge after the operands.

module compMul2to1 import encArithPkg::*; (
    input  logic clk,
    input  elemT a,                                 // Key element.
    input  elemT b,                                 // Plaintext element.
    output prodT prod                               // Full product, registered.
);

    // ************************************************************
    // Multiply stage.
    // ************************************************************

    prodT prodNext;                                 // Combinational product.

    // Widen both operands first so the product keeps all 16 bits.
    always_comb begin
        prodNext = prodT'(a) * prodT'(b);
    end

    // Payload register. Idle operands are zero upstream.
    always_ff @(posedge clk) begin
        prod <= prodNext;
    end

endmodule

`default_nettype wire

//--- compSum4to1.sv
`default_nettype none
`timescale 1ns/1ps

// Registered 4-to-1 adder of products.
// Sum and carry are valid one edge after the products.

module compSum4to1 import encArithPkg::*; (
    input  logic clk,
    input  logic reset,
    input  prodT p0,
    input  prodT p1,
    input  prodT p2,
    input  prodT p3,
    output sumT  sum,                               // Low 16 bits of the total.
    output logic carry                              // Total reached 65536 or more.
);

    // ************************************************************
    // Add stage.
    // ************************************************************

    logic [sumExtWidth-1:0] sumExt;                 // Full width total.

    // Extend before adding so no bit is lost.
    always_comb begin
        sumExt = sumExtWidth'(p0) + sumExtWidth'(p1)
               + sumExtWidth'(p2) + sumExtWidth'(p3);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum   <= '0;
            carry <= 1'b0;
        end else begin
            sum   <= sumExt[prodWidth-1:0];         // Truncated row sum.
            carry <= |sumExt[sumExtWidth-1:prodWidth]; // Any bit above 16.
        end
    end

    // ************************************************************
    // Checks.
    // ************************************************************

    // Without overflow the sum cannot be below any of its terms.
    noWrapSum : assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && !carry) |->
            (sum >= $past(p0)) && (sum >= $past(p1)) &&
            (sum >= $past(p2)) && (sum >= $past(p3)))
        else $error("Row sum smaller than a product without carry.");

endmodule

`default_nettype wire

//--- encArithPkg.sv
`default_nettype none

// ************************************************************
// Arithmetic types of the encoder datapath.
// ************************************************************

package encArithPkg;

    // Element and product widths.
    localparam int elemWidth = 8;                   // Key and plaintext element.
    localparam int prodWidth = 16;                  // Full 8x8 product.

    // Four products need two extra bits before truncation.
    localparam int sumExtWidth = prodWidth + 2;

    // One unsigned key or plaintext element.
    typedef logic [elemWidth-1:0] elemT;

    // One element product. An 8x8 product always fits here.
    typedef logic [prodWidth-1:0] prodT;

    // One row sum, truncated to 16 bits.
    // The overflow bit travels separately as carry.
    typedef logic [prodWidth-1:0] sumT;

endpackage

`default_nettype wire

//--- encCtrlPkg.sv
`default_nettype none

// ************************************************************
// Shape and timing of the key matrix engine.
// ************************************************************

package encCtrlPkg;

    localparam int matDim  = 4;                     // Rows and columns of the key.
    localparam int matSize = matDim * matDim;       // Elements in the key.

    // Row or column index into the key matrix.
    typedef logic [$clog2(matDim)-1:0] keyIdxT;

    // Edges from an accepted vector to its result.
    localparam int pipeLatency = 2;

endpackage

`default_nettype wire

//--- encKeyStore.sv
`default_nettype none
`timescale 1ns/1ps

// Key matrix register file.
// One element written per strobe, all sixteen read in parallel.

module encKeyStore
    import encArithPkg::*;
    import encCtrlPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               keyWrite,       // Write strobe.
    input  keyIdxT             keyRow,
    input  keyIdxT             keyCol,
    input  elemT               keyData,
    output elemT [matSize-1:0] keyMat          // Row-major key.
);

    // Flat element address is {row, col}.
    localparam int addrWidth = 2 * $bits(keyIdxT);

    logic [addrWidth-1:0] keyAddr;             // Row-major element address.
    logic [matSize-1:0]   wrEn;                // One-hot write enable.
    elemT [matSize-1:0]   keyReg;              // Key elements.

    assign keyAddr = {keyRow, keyCol};         // Equals 4*row + col.

    // ************************************************************
    // Write decode.
    // ************************************************************

    always_comb begin
        for (int i = 0; i < matSize; i++) begin
            wrEn[i] = keyWrite && (keyAddr == addrWidth'(i));
        end
    end

    // ************************************************************
    // Storage.
    // ************************************************************

    // A vector sampled at the write edge still sees the old key.
    always_ff @(posedge clk) begin
        if (reset) begin
            keyReg <= '0;                      // All-zero key.
        end else begin
            for (int i = 0; i < matSize; i++) begin
                if (wrEn[i]) begin
                    keyReg[i] <= keyData;
                end
            end
        end
    end

    // Parallel read straight from the registers.
    assign keyMat = keyReg;

    // ************************************************************
    // Checks.
    // ************************************************************

    // An unknown address or data would corrupt the key silently.
    keyWriteKnown : assert property (@(posedge clk) disable iff (reset)
        keyWrite |-> !$isunknown({keyRow, keyCol, keyData}))
        else $error("Key write with unknown address or data.");

endmodule

`default_nettype wire

//--- encMatrixEngine.f
encArithPkg.sv
encCtrlPkg.sv
compMul2to1.sv
compSum4to1.sv
modEncMultiplicator.sv
encKeyStore.sv
encMatrixEngine.sv
tbEncMatrixEngine.sv

//--- encMatrixEngine.sv
`default_nettype none
`timescale 1ns/1ps

// Hill-style block encoder top.
// Key store feeds the multiplicator. Result follows a vector by two edges.

module encMatrixEngine
    import encArithPkg::*;
    import encCtrlPkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // Key load.
    input  logic              keyWrite,
    input  keyIdxT            keyRow,
    input  keyIdxT            keyCol,
    input  elemT              keyData,

    // Plaintext vector.
    input  logic              vecValid,
    input  elemT [matDim-1:0] vecData,

    // Encoded vector.
    output logic              outValid,
    output sumT  [matDim-1:0] out,
    output logic [matDim-1:0] carry
);

    elemT [matSize-1:0] keyMat;                // Key, row-major.
    elemT [matSize-1:0] matB;                  // Vector copied once per row.

    // ************************************************************
    // Vector replication.
    // ************************************************************

    // Element 4r+c pairs key[r][c] with vecData[c].
    for (genvar r = 0; r < matDim; r++) begin : gRow
        for (genvar c = 0; c < matDim; c++) begin : gCol
            assign matB[matDim*r + c] = vecData[c];
        end
    end

    encKeyStore i_encKeyStore (
        .clk      (clk),
        .reset    (reset),
        .keyWrite (keyWrite),
        .keyRow   (keyRow),
        .keyCol   (keyCol),
        .keyData  (keyData),
        .keyMat   (keyMat)
    );

    modEncMultiplicator i_modEncMultiplicator (
        .clk      (clk),
        .reset    (reset),
        .inValid  (vecValid),
        .matA     (keyMat),
        .matB     (matB),
        .outValid (outValid),
        .out      (out),
        .carry    (carry)
    );

endmodule

`default_nettype wire

//--- modEncMultiplicator.sv
`default_nettype none
`timescale 1ns/1ps

// Matrix-vector multiplicator.
// Sixteen element products feed four row summers.
// Row r takes elements 4r to 4r+3 of both operands.

module modEncMultiplicator
    import encArithPkg::*;
    import encCtrlPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                inValid,        // Operand pulse.
    input  elemT [matSize-1:0]  matA,           // Key, row-major.
    input  elemT [matSize-1:0]  matB,           // Vector, one copy per row.
    output logic                outValid,       // Result pulse.
    output sumT  [matDim-1:0]   out,            // Row sums.
    output logic [matDim-1:0]   carry           // Row overflow bits.
);

    elemT [matSize-1:0] opB;                    // Gated vector operand.
    prodT [matSize-1:0] prodMat;                // Registered products.
    logic [pipeLatency-1:0] validPipe;          // Valid shift register.

    // ************************************************************
    // Multiply stage.
    // ************************************************************

    // Idle cycles feed zeros, so out holds zero between results.
    for (genvar i = 0; i < matSize; i++) begin : gMul
        assign opB[i] = inValid ? matB[i] : '0;

        compMul2to1 i_compMul2to1 (
            .clk  (clk),
            .a    (matA[i]),
            .b    (opB[i]),
            .prod (prodMat[i])
        );
    end

    // ************************************************************
    // Sum stage.
    // ************************************************************

    for (genvar r = 0; r < matDim; r++) begin : gSum
        compSum4to1 i_compSum4to1 (
            .clk   (clk),
            .reset (reset),
            .p0    (prodMat[matDim*r + 0]),
            .p1    (prodMat[matDim*r + 1]),
            .p2    (prodMat[matDim*r + 2]),
            .p3    (prodMat[matDim*r + 3]),
            .sum   (out[r]),
            .carry (carry[r])
        );
    end

    // Valid follows the data through both register stages.
    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[pipeLatency-2:0], inValid};
        end
    end

    assign outValid = validPipe[pipeLatency-1];  // Oldest stage.

    // ************************************************************
    // Checks.
    // ************************************************************

    validKnown : assert property (@(posedge clk) disable iff (reset)
        !$isunknown(outValid))
        else $error("outValid unknown after reset.");

    // Result pulse lines up with the operand pulse of two edges back.
    validLatency : assert property (@(posedge clk) disable iff (reset)
        (!$past(reset, 1) && !$past(reset, pipeLatency)) |->
            (outValid == $past(inValid, pipeLatency)))
        else $error("outValid out of step with inValid.");

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build and run the encoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tbEncMatrixEngine \
    -f encMatrixEngine.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed."
    exit 1
fi

./obj_dir/VtbEncMatrixEngine > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus."
    exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log."
exit 1

//--- tbEncMatrixEngine.sv
`default_nettype none
`timescale 1ns/1ps

module tbEncMatrixEngine import encArithPkg::*; import encCtrlPkg::*; ();

    // Expected result of one vector, with the edge count at which it shows.
    typedef struct packed {
        sumT  [matDim-1:0] sums;
        logic [matDim-1:0] carries;
        int                due;
    } resT;

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic              keyWrite = 1'b0;
    keyIdxT            keyRow = '0;
    keyIdxT            keyCol = '0;
    elemT              keyData = '0;
    logic              vecValid = 1'b0;
    elemT [matDim-1:0] vecData = '0;
    logic              outValid;
    sumT  [matDim-1:0] out;
    logic [matDim-1:0] carry;

    elemT modelKey [matDim][matDim];                // Model copy of the key.
    resT  expQ [$];                                 // Results still in flight.
    int   cycleCnt = 0;                             // Rising edges seen.
    int   carrySeen = 0;                            // Carry bits seen on outputs.
    logic resultSeen = 1'b0;                        // First result has shown.

    encMatrixEngine i_encMatrixEngine (
        .clk(clk), .reset(reset), .keyWrite(keyWrite), .keyRow(keyRow), .keyCol(keyCol),
        .keyData(keyData), .vecValid(vecValid), .vecData(vecData), .outValid(outValid),
        .out(out), .carry(carry)
    );

    always #10 clk = ~clk;                          // 20 ns period.

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // ************************************************************
    // Failure reporting and compares.
    // ************************************************************

    task automatic stopOnMismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first wrong value.");
    endtask

    task automatic stopOnTimeout(input string msg);
        $display("timeout at %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped on a timeout.");
    endtask

    task automatic checkSum(input sumT expSum, input sumT actSum, input int row);
        if (expSum !== actSum)
            stopOnMismatch($sformatf("row %0d sum %h, expected %h", row, actSum, expSum));
    endtask

    task automatic checkCarry(input logic expCarry, input logic actCarry, input int row);
        if (expCarry !== actCarry)
            stopOnMismatch($sformatf("row %0d carry %b, expected %b", row, actCarry, expCarry));
    endtask

    task automatic checkValid(input logic expValid, input logic actValid);
        if (expValid !== actValid)
            stopOnMismatch($sformatf("outValid %b, expected %b", actValid, expValid));
    endtask

    // ************************************************************
    // Reference model.
    // ************************************************************

    // Row r is the dot product of key row r with the vector, kept at 18 bits.
    function automatic resT modelResult(input elemT [matDim-1:0] v);
        resT        res;
        logic [17:0] acc;
        res = '0;
        for (int r = 0; r < matDim; r++) begin
            acc = '0;
            for (int c = 0; c < matDim; c++) begin
                acc = acc + 18'(modelKey[r][c]) * 18'(v[c]);
            end
            res.sums[r]    = acc[15:0];             // Low 16 bits.
            res.carries[r] = (acc >= 18'd65536);    // Overflow past 16 bits.
        end
        return res;
    endfunction

    function automatic elemT [matDim-1:0] randVec(input elemT lo, input elemT hi);
        elemT [matDim-1:0] v;
        for (int c = 0; c < matDim; c++) v[c] = elemT'($urandom_range(hi, lo));
        return v;
    endfunction

    // Results are stable at the falling edge.
    always @(negedge clk) begin
        logic expValid;
        resT  expRes;
        if (!reset) begin
            expValid = 1'b0;
            if (expQ.size() != 0) expValid = (expQ[0].due == cycleCnt);
            checkValid(expValid, outValid);
            if (outValid) begin
                expRes = expQ.pop_front();
                for (int r = 0; r < matDim; r++) begin
                    checkSum(expRes.sums[r], out[r], r);
                    checkCarry(expRes.carries[r], carry[r], r);
                end
                carrySeen  = carrySeen + $countones(carry);
                resultSeen = 1'b1;
            end else if (!resultSeen) begin
                // Reset value holds until the first result.
                for (int r = 0; r < matDim; r++) begin
                    checkSum('0, out[r], r);
                    checkCarry(1'b0, carry[r], r);
                end
            end
        end
    end

    // ************************************************************
    // Stimulus.
    // ************************************************************

    // One cycle of inputs. A vector here sees the key before this write.
    task automatic driveCycle(input logic doKey, input keyIdxT row, input keyIdxT col,
                              input elemT data, input logic doVec,
                              input elemT [matDim-1:0] vec);
        resT res;
        @(posedge clk);
        #1;
        keyWrite = doKey;
        keyRow   = row;
        keyCol   = col;
        keyData  = data;
        vecValid = doVec;
        vecData  = vec;
        if (doVec) begin
            res     = modelResult(vec);
            res.due = cycleCnt + pipeLatency;       // Shows pipeLatency edges from here.
            expQ.push_back(res);
        end
        if (doKey) modelKey[row][col] = data;
    endtask

    task automatic loadKey(input elemT lo, input elemT hi);
        for (int r = 0; r < matDim; r++)
            for (int c = 0; c < matDim; c++)
                driveCycle(1'b1, keyIdxT'(r), keyIdxT'(c), elemT'($urandom_range(hi, lo)),
                           1'b0, '0);
    endtask

    // Idle inputs, then wait until every result has come back.
    task automatic waitDrain();
        int waited;
        waited = 0;
        driveCycle(1'b0, '0, '0, '0, 1'b0, '0);
        while (expQ.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 4 * pipeLatency + 4)
                stopOnTimeout($sformatf("result never arrived, %0d pending", expQ.size()));
        end
    endtask

    initial begin
        keyIdxT            wr;
        keyIdxT            wc;
        elemT [matDim-1:0] v;
        int                carryBase;
        void'($urandom(32'h7ef5));
        for (int r = 0; r < matDim; r++)
            for (int c = 0; c < matDim; c++) modelKey[r][c] = '0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // Quiet outputs, then one vector against the cleared key.
        repeat (5) driveCycle(1'b0, '0, '0, '0, 1'b0, '0);
        driveCycle(1'b0, '0, '0, '0, 1'b1, randVec(8'd1, 8'd255));
        waitDrain();

        loadKey(8'd0, 8'd255);                      // Single vectors.
        repeat (5) begin
            driveCycle(1'b0, '0, '0, '0, 1'b1, randVec(8'd0, 8'd255));
            waitDrain();
        end
        repeat (8) driveCycle(1'b0, '0, '0, '0, 1'b1, randVec(8'd0, 8'd255)); // Back to back.
        waitDrain();

        // Key write and vector at the same edge, then the same vector again.
        wr = keyIdxT'($urandom_range(3, 0));
        wc = keyIdxT'($urandom_range(3, 0));
        v  = randVec(8'd1, 8'd255);
        driveCycle(1'b1, wr, wc, modelKey[wr][wc] ^ 8'hA5, 1'b1, v);
        driveCycle(1'b0, '0, '0, '0, 1'b1, v);
        waitDrain();

        carryBase = carrySeen;                      // All ones overflow every row.
        loadKey(8'd255, 8'd255);
        repeat (3) driveCycle(1'b0, '0, '0, '0, 1'b1, randVec(8'd255, 8'd255));
        waitDrain();
        if (carrySeen - carryBase != 3 * matDim)
            stopOnMismatch("carry not set on every row with an all-ones key");
        carryBase = carrySeen;                      // Small values never overflow.
        loadKey(8'd0, 8'd15);
        repeat (5) driveCycle(1'b0, '0, '0, '0, 1'b1, randVec(8'd0, 8'd15));
        waitDrain();
        if (carrySeen != carryBase)
            stopOnMismatch("carry set although every element is below 16");

        // Long random mix with gaps.
        repeat (400)
            driveCycle($urandom_range(99, 0) < 25, keyIdxT'($urandom_range(3, 0)),
                       keyIdxT'($urandom_range(3, 0)), elemT'($urandom_range(255, 0)),
                       $urandom_range(99, 0) < 60, randVec(8'd0, 8'd255));
        waitDrain();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
